//--- Bender.yml
package:
  name: mac_loopback

sources:
  - files:
      - logic/loopback_pkg.sv
      - logic/reg_map_pkg.sv
      - logic/xgmac_address_swap.sv
      - logic/frame_stats.sv
      - logic/loopback_regs.sv
      - logic/mac_loopback.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_mac_loopback.sv

//--- dv/tb_tasks.svh
// Included inside the testbench module; every task here starts and ends on a falling clock edge
`ifndef tb_tasks_svh
`define tb_tasks_svh

// Ends the run at the first failure
task automatic fail_run(input string why);
   $display("%s", why);
   $display("Checks failed");
   $fatal(1);
endtask

task automatic expect_equal(input string name, input logic [63:0] got, input logic [63:0] want);
   if (got !== want) begin
      fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, want));
   end
endtask

// cs pulse, then the ack is due exactly one cycle later
task automatic read_reg(input logic [addr_w-1:0] addr, input logic want_err,
                        output logic [reg_w-1:0] data);
   bus2ip_addr = addr;
   bus2ip_rnw  = 1'b1;
   bus2ip_cs   = 1'b1;
   @(negedge clk);
   bus2ip_cs = 1'b0;
   @(posedge clk);
   expect_equal("ip2bus_rdack", ip2bus_rdack, 1'b1);
   expect_equal("ip2bus_wrack", ip2bus_wrack, 1'b0);
   expect_equal("ip2bus_error", ip2bus_error, want_err);
   data = ip2bus_data;
   @(negedge clk);
endtask

task automatic write_reg(input logic [addr_w-1:0] addr, input logic [reg_w-1:0] data,
                         input logic want_err);
   bus2ip_addr = addr;
   bus2ip_data = data;
   bus2ip_rnw  = 1'b0;
   bus2ip_cs   = 1'b1;
   @(negedge clk);
   bus2ip_cs = 1'b0;
   @(posedge clk);
   expect_equal("ip2bus_wrack", ip2bus_wrack, 1'b1);
   expect_equal("ip2bus_rdack", ip2bus_rdack, 1'b0);
   expect_equal("ip2bus_error", ip2bus_error, want_err);
   @(negedge clk);
endtask

task automatic expect_reg(input string name, input logic [addr_w-1:0] addr,
                          input logic [reg_w-1:0] want);
   logic [reg_w-1:0] data;
   read_reg(addr, 1'b0, data);
   expect_equal(name, data, want);
endtask

// Byte-counting frame; swap says whether the header exchange is expected
task automatic send_frame(input int nbeats, input int last_bytes, input bit good,
                          input bit swap, input bit gaps);
   logic [10*data_w-1:0] raw;
   logic [10*data_w-1:0] want;
   logic [keep_w-1:0]    last_keep;
   raw       = '0;
   last_keep = 8'hff >> (keep_w - last_bytes);
   for (int i = 0; i < nbeats * keep_w; i++) begin
      raw[i*8 +: 8] = frame_base + 8'(i);
   end
   frame_base = frame_base + 8'h25;
   want = raw;
   if (swap && nbeats > 1) begin // Single beat frames stay as they are
      for (int i = 0; i < mac_bytes; i++) begin
         want[i*8 +: 8]               = raw[(i + mac_bytes)*8 +: 8];
         want[(i + mac_bytes)*8 +: 8] = raw[i*8 +: 8];
      end
   end
   for (int b = 0; b < nbeats; b++) begin
      exp_data.push_back(want[b*data_w +: data_w]);
      exp_keep.push_back((b == nbeats - 1) ? last_keep : 8'hff);
      exp_last.push_back(b == nbeats - 1);
   end
   for (int b = 0; b < nbeats; b++) begin
      if (gaps) begin
         while (take_bit()) begin // Idle cycle
            rx_axis_tvalid = 1'b0;
            @(negedge clk);
         end
      end
      rx_axis_tdata  = raw[b*data_w +: data_w];
      rx_axis_tkeep  = (b == nbeats - 1) ? last_keep : 8'hff;
      rx_axis_tlast  = (b == nbeats - 1);
      rx_axis_tuser  = good && (b == nbeats - 1);
      rx_axis_tvalid = 1'b1;
      @(posedge clk);
      while (!rx_axis_tready) @(posedge clk); // Held until taken
      @(negedge clk);
   end
   rx_axis_tvalid = 1'b0;
   rx_axis_tlast  = 1'b0;
   rx_axis_tuser  = 1'b0;
endtask

// Until every expected beat has left the DUT
task automatic wait_drain();
   while (exp_data.size() != 0) @(negedge clk);
endtask

task automatic check_reset_state();
   expect_equal("tx_axis_tvalid", tx_axis_tvalid, 1'b0);
   expect_equal("ip2bus_rdack", ip2bus_rdack, 1'b0);
   expect_equal("ip2bus_wrack", ip2bus_wrack, 1'b0);
   expect_equal("ip2bus_error", ip2bus_error, 1'b0);
   expect_reg("id", reg_id, core_id);
   expect_reg("ctrl", reg_ctrl, 32'h1);
   expect_reg("rx_good", reg_rx_good, 32'h0);
   expect_reg("rx_bad", reg_rx_bad, 32'h0);
   expect_reg("tx_frames", reg_tx_frames, 32'h0);
endtask

task automatic loop_frames_ready_high();
   for (int n = 2; n <= 9; n++) begin
      send_frame(n, 7 - ((n - 2) % 7), 1'b1, 1'b1, 1'b0); // Last keep 7 down to 1 bytes
   end
   wait_drain();
endtask

task automatic loop_frames_backpressure();
   random_ready = 1'b1;
   for (int n = 2; n <= 9; n++) begin
      send_frame(n, 7 - ((n - 2) % 7), 1'b1, 1'b1, 1'b1);
   end
   wait_drain();
   random_ready = 1'b0;
   @(negedge clk);
endtask

task automatic pass_through_unswapped();
   write_reg(reg_ctrl, 32'h0, 1'b0);
   expect_reg("ctrl", reg_ctrl, 32'h0);
   for (int n = 2; n <= 4; n++) begin
      send_frame(n, 4, 1'b1, 1'b0, 1'b0);
   end
   wait_drain();
   write_reg(reg_ctrl, 32'h1, 1'b0);
   send_frame(1, 8, 1'b1, 1'b1, 1'b0); // Swap on, still untouched
   wait_drain();
endtask

task automatic count_and_clear();
   write_reg(reg_ctrl, 32'h3, 1'b0); // Clear, swap stays on
   expect_reg("ctrl", reg_ctrl, 32'h1);
   send_frame(3, 5, 1'b1, 1'b1, 1'b0);
   send_frame(3, 5, 1'b0, 1'b1, 1'b0);
   send_frame(3, 5, 1'b1, 1'b1, 1'b0);
   send_frame(3, 5, 1'b0, 1'b1, 1'b0);
   send_frame(3, 5, 1'b1, 1'b1, 1'b0);
   wait_drain();
   expect_reg("rx_good", reg_rx_good, 32'd3);
   expect_reg("rx_bad", reg_rx_bad, 32'd2);
   expect_reg("tx_frames", reg_tx_frames, 32'd5);
   write_reg(reg_ctrl, 32'h3, 1'b0);
   expect_reg("rx_good", reg_rx_good, 32'h0);
   expect_reg("rx_bad", reg_rx_bad, 32'h0);
   expect_reg("tx_frames", reg_tx_frames, 32'h0);
endtask

task automatic unmapped_access();
   logic [reg_w-1:0] data;
   read_reg(11'h7F0, 1'b1, data);
   write_reg(11'h7F0, 32'h0, 1'b1); // Would turn swap off if decoded as ctrl
   expect_reg("ctrl", reg_ctrl, 32'h1);
endtask

`endif

//--- dv/tb_mac_loopback.sv
// Directed testbench; frames up to 10 beats, one shared LFSR feeds both rx gaps and tx back-pressure
`timescale 1ns/1ps

module tb_mac_loopback;
   import loopback_pkg::*;
   import reg_map_pkg::*;

   localparam int clk_period   = 8;   // ns
   localparam int reset_cycles = 10;
   localparam int total_beats  = 113; // All frames of all tests
   localparam int total_bus    = 20;  // Register accesses
   localparam int watchdog_cycles = reset_cycles + 200 * total_beats + 10 * total_bus;

   logic              clk;
   logic              rst_n;
   logic [data_w-1:0] rx_axis_tdata;
   logic [keep_w-1:0] rx_axis_tkeep;
   logic              rx_axis_tlast;
   logic              rx_axis_tuser;
   logic              rx_axis_tvalid;
   logic              rx_axis_tready;
   logic [data_w-1:0] tx_axis_tdata;
   logic [keep_w-1:0] tx_axis_tkeep;
   logic              tx_axis_tlast;
   logic              tx_axis_tvalid;
   logic              tx_axis_tready;
   logic [addr_w-1:0] bus2ip_addr;
   logic [reg_w-1:0]  bus2ip_data;
   logic              bus2ip_cs;
   logic              bus2ip_rnw;
   logic [reg_w-1:0]  ip2bus_data;
   logic              ip2bus_rdack;
   logic              ip2bus_wrack;
   logic              ip2bus_error;

   logic [31:0]       lfsr;         // Random source state
   bit                random_ready; // tx_axis_tready from the LFSR
   logic [7:0]        frame_base;   // First payload byte of the next frame
   logic [data_w-1:0] exp_data[$];  // Expected tx beats, oldest first
   logic [keep_w-1:0] exp_keep[$];
   logic              exp_last[$];

   mac_loopback u_dut (
      .clk            (clk),
      .rst_n          (rst_n),
      .rx_axis_tdata  (rx_axis_tdata),
      .rx_axis_tkeep  (rx_axis_tkeep),
      .rx_axis_tlast  (rx_axis_tlast),
      .rx_axis_tuser  (rx_axis_tuser),
      .rx_axis_tvalid (rx_axis_tvalid),
      .rx_axis_tready (rx_axis_tready),
      .tx_axis_tdata  (tx_axis_tdata),
      .tx_axis_tkeep  (tx_axis_tkeep),
      .tx_axis_tlast  (tx_axis_tlast),
      .tx_axis_tvalid (tx_axis_tvalid),
      .tx_axis_tready (tx_axis_tready),
      .bus2ip_addr    (bus2ip_addr),
      .bus2ip_data    (bus2ip_data),
      .bus2ip_cs      (bus2ip_cs),
      .bus2ip_rnw     (bus2ip_rnw),
      .ip2bus_data    (ip2bus_data),
      .ip2bus_rdack   (ip2bus_rdack),
      .ip2bus_wrack   (ip2bus_wrack),
      .ip2bus_error   (ip2bus_error)
   );

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic take_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   `include "tb_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // Sink readiness, changed on the falling edge
   always @(negedge clk) begin
      if (random_ready) begin
         tx_axis_tready = take_bit();
      end else begin
         tx_axis_tready = 1'b1;
      end
   end

   // Tx monitor against the expected queue
   always @(posedge clk) begin
      if (rst_n && tx_axis_tvalid && tx_axis_tready) begin
         if (exp_data.size() == 0) begin
            fail_run("A tx beat came out while no frame was pending");
         end else begin
            expect_equal("tx_axis_tdata", tx_axis_tdata, exp_data.pop_front());
            expect_equal("tx_axis_tkeep", tx_axis_tkeep, exp_keep.pop_front());
            expect_equal("tx_axis_tlast", tx_axis_tlast, exp_last.pop_front());
         end
      end
   end

   // Watchdog
   initial begin
      #(watchdog_cycles * clk_period);
      fail_run("The run timed out before all tests finished");
   end

   initial begin
      rst_n          = 1'b0;
      rx_axis_tdata  = '0;
      rx_axis_tkeep  = '0;
      rx_axis_tlast  = 1'b0;
      rx_axis_tuser  = 1'b0;
      rx_axis_tvalid = 1'b0;
      tx_axis_tready = 1'b1;
      bus2ip_addr    = '0;
      bus2ip_data    = '0;
      bus2ip_cs      = 1'b0;
      bus2ip_rnw     = 1'b0;
      lfsr           = 32'h66ea_f0ae;
      random_ready   = 1'b0;
      frame_base     = 8'h00;
      repeat (reset_cycles) @(posedge clk); // Ten rising edges in reset
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_reset_state();
      loop_frames_ready_high();
      loop_frames_backpressure();
      pass_through_unswapped();
      count_and_clear();
      unmapped_access();
      $display("All checks passed");
      $finish;
   end

endmodule

//--- logic/frame_stats.sv
// Counts frames on their accepted last beat; counters saturate and a clear wins over any event
`timescale 1ns/1ps

module frame_stats (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           stats_clear,
   input  logic                           rx_axis_tvalid,
   input  logic                           rx_axis_tready,
   input  logic                           rx_axis_tlast,
   input  logic                           rx_axis_tuser,
   input  logic                           tx_axis_tvalid,
   input  logic                           tx_axis_tready,
   input  logic                           tx_axis_tlast,
   output logic [reg_map_pkg::cnt_w-1:0]  rx_good,
   output logic [reg_map_pkg::cnt_w-1:0]  rx_bad,
   output logic [reg_map_pkg::cnt_w-1:0]  tx_frames
);
   import reg_map_pkg::*;

   logic rx_done; // Last rx beat taken
   logic tx_done; // Last tx beat taken

   // Hold at all ones instead of wrapping
   function automatic logic [cnt_w-1:0] sat_inc(input logic [cnt_w-1:0] cnt);
      return (&cnt) ? cnt : cnt + 1'b1;
   endfunction

   assign rx_done = rx_axis_tvalid && rx_axis_tready && rx_axis_tlast;
   assign tx_done = tx_axis_tvalid && tx_axis_tready && tx_axis_tlast;

   always_ff @(posedge clk) begin
      if (!rst_n || stats_clear) begin
         rx_good   <= '0;
         rx_bad    <= '0;
         tx_frames <= '0;
      end else begin
         if (rx_done && rx_axis_tuser) begin
            rx_good <= sat_inc(rx_good); // tuser marks a good FCS
         end
         if (rx_done && !rx_axis_tuser) begin
            rx_bad <= sat_inc(rx_bad);
         end
         if (tx_done) begin
            tx_frames <= sat_inc(tx_frames);
         end
      end
   end

   // Clear beats a coincident increment
   a_clear_wins: assert property (@(posedge clk) disable iff (!rst_n)
      stats_clear && (rx_done || tx_done) |=>
         (rx_good == '0) && (rx_bad == '0) && (tx_frames == '0));

endmodule

//--- logic/loopback_pkg.sv
// Stream geometry for a little-endian 64-bit AXI-stream; the MAC header must fit in two beats
package loopback_pkg;

   // Stream geometry
   localparam int data_w = 64;              // AXI-stream data width
   localparam int keep_w = data_w / 8;      // One keep bit per byte
   localparam int byte_w = data_w / keep_w; // Bits per byte lane

   // Ethernet header layout, in bytes from frame start
   localparam int mac_bytes = 6; // One MAC address
   localparam int dst_ofs   = 0; // Destination MAC
   localparam int src_ofs   = 6; // Source MAC follows directly

   // Address swap pipeline state
   // Idle leaves the hold register empty
   // First_held keeps beat 0 until beat 1 arrives
   // Streaming holds a later beat, or a one-beat frame
   typedef enum logic [1:0] {
      swap_idle       = 2'd0,
      swap_first_held = 2'd1,
      swap_streaming  = 2'd2
   } swap_state_e;

endpackage

//--- logic/loopback_regs.sv
// bus2ip slave; cs must be a one-cycle pulse, answered one cycle later by rdack or wrack
`timescale 1ns/1ps

module loopback_regs (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [reg_map_pkg::addr_w-1:0] bus2ip_addr,
   input  logic [reg_map_pkg::reg_w-1:0]  bus2ip_data,
   input  logic                           bus2ip_cs,
   input  logic                           bus2ip_rnw,
   output logic [reg_map_pkg::reg_w-1:0]  ip2bus_data,
   output logic                           ip2bus_rdack,
   output logic                           ip2bus_wrack,
   output logic                           ip2bus_error,
   input  logic [reg_map_pkg::cnt_w-1:0]  rx_good,
   input  logic [reg_map_pkg::cnt_w-1:0]  rx_bad,
   input  logic [reg_map_pkg::cnt_w-1:0]  tx_frames,
   output logic                           swap_en,
   output logic                           stats_clear
);
   import reg_map_pkg::*;

   bus_op_e          op;
   reg_addr_e        addr;
   logic             mapped; // Address hits a register
   logic [reg_w-1:0] rd_val;
   logic             ctrl_wr;

   assign op      = bus2ip_rnw ? bus_read : bus_write;
   assign addr    = reg_addr_e'(bus2ip_addr);
   assign ctrl_wr = bus2ip_cs && (op == bus_write) && (addr == reg_ctrl);

   // Read mux, zero on a miss
   always_comb begin
      mapped = 1'b1;
      rd_val = '0;
      case (addr)
         reg_id:        rd_val = core_id;
         reg_ctrl:      rd_val[ctrl_swap_en_bit] = swap_en; // Clear bit reads 0
         reg_rx_good:   rd_val[cnt_w-1:0] = rx_good;
         reg_rx_bad:    rd_val[cnt_w-1:0] = rx_bad;
         reg_tx_frames: rd_val[cnt_w-1:0] = tx_frames;
         default:       mapped = 1'b0;
      endcase
   end

   // Acks one cycle after cs
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ip2bus_rdack <= 1'b0;
         ip2bus_wrack <= 1'b0;
         ip2bus_error <= 1'b0;
      end else begin
         ip2bus_rdack <= bus2ip_cs && (op == bus_read);
         ip2bus_wrack <= bus2ip_cs && (op == bus_write);
         ip2bus_error <= bus2ip_cs && !mapped;
      end
   end

   always_ff @(posedge clk) begin
      if (bus2ip_cs && (op == bus_read)) begin
         ip2bus_data <= rd_val;
      end
   end

   // Control register; clear pulses alongside wrack
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         swap_en     <= 1'b1;
         stats_clear <= 1'b0;
      end else begin
         stats_clear <= ctrl_wr && bus2ip_data[ctrl_clear_bit];
         if (ctrl_wr) begin
            swap_en <= bus2ip_data[ctrl_swap_en_bit];
         end
      end
   end

   a_ack_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(ip2bus_rdack && ip2bus_wrack));

   // One ack per access, then quiet
   a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
      bus2ip_cs |=> (ip2bus_rdack != ip2bus_wrack) ##1 !(ip2bus_rdack || ip2bus_wrack));

endmodule

//--- logic/mac_loopback.sv
// Single-clock loopback core; MAC/PHY sits outside, swap on by default after reset
`timescale 1ns/1ps

module mac_loopback (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [loopback_pkg::data_w-1:0] rx_axis_tdata,
   input  logic [loopback_pkg::keep_w-1:0] rx_axis_tkeep,
   input  logic                            rx_axis_tlast,
   input  logic                            rx_axis_tuser,
   input  logic                            rx_axis_tvalid,
   output logic                            rx_axis_tready,
   output logic [loopback_pkg::data_w-1:0] tx_axis_tdata,
   output logic [loopback_pkg::keep_w-1:0] tx_axis_tkeep,
   output logic                            tx_axis_tlast,
   output logic                            tx_axis_tvalid,
   input  logic                            tx_axis_tready,
   input  logic [reg_map_pkg::addr_w-1:0]  bus2ip_addr,
   input  logic [reg_map_pkg::reg_w-1:0]   bus2ip_data,
   input  logic                            bus2ip_cs,
   input  logic                            bus2ip_rnw,
   output logic [reg_map_pkg::reg_w-1:0]   ip2bus_data,
   output logic                            ip2bus_rdack,
   output logic                            ip2bus_wrack,
   output logic                            ip2bus_error
);
   import reg_map_pkg::*;

   logic             swap_en;     // From control reg
   logic             stats_clear; // One-cycle pulse
   logic [cnt_w-1:0] rx_good;
   logic [cnt_w-1:0] rx_bad;
   logic [cnt_w-1:0] tx_frames;

   xgmac_address_swap u_swap (
      .clk            (clk),
      .rst_n          (rst_n),
      .swap_en        (swap_en),
      .rx_axis_tdata  (rx_axis_tdata),
      .rx_axis_tkeep  (rx_axis_tkeep),
      .rx_axis_tlast  (rx_axis_tlast),
      .rx_axis_tvalid (rx_axis_tvalid),
      .rx_axis_tready (rx_axis_tready),
      .tx_axis_tdata  (tx_axis_tdata),
      .tx_axis_tkeep  (tx_axis_tkeep),
      .tx_axis_tlast  (tx_axis_tlast),
      .tx_axis_tvalid (tx_axis_tvalid),
      .tx_axis_tready (tx_axis_tready)
   );

   // Taps both handshakes at the ports
   frame_stats u_stats (
      .clk            (clk),
      .rst_n          (rst_n),
      .stats_clear    (stats_clear),
      .rx_axis_tvalid (rx_axis_tvalid),
      .rx_axis_tready (rx_axis_tready),
      .rx_axis_tlast  (rx_axis_tlast),
      .rx_axis_tuser  (rx_axis_tuser),
      .tx_axis_tvalid (tx_axis_tvalid),
      .tx_axis_tready (tx_axis_tready),
      .tx_axis_tlast  (tx_axis_tlast),
      .rx_good        (rx_good),
      .rx_bad         (rx_bad),
      .tx_frames      (tx_frames)
   );

   loopback_regs u_regs (
      .clk          (clk),
      .rst_n        (rst_n),
      .bus2ip_addr  (bus2ip_addr),
      .bus2ip_data  (bus2ip_data),
      .bus2ip_cs    (bus2ip_cs),
      .bus2ip_rnw   (bus2ip_rnw),
      .ip2bus_data  (ip2bus_data),
      .ip2bus_rdack (ip2bus_rdack),
      .ip2bus_wrack (ip2bus_wrack),
      .ip2bus_error (ip2bus_error),
      .rx_good      (rx_good),
      .rx_bad       (rx_bad),
      .tx_frames    (tx_frames),
      .swap_en      (swap_en),
      .stats_clear  (stats_clear)
   );

endmodule

//--- logic/reg_map_pkg.sv
// Register map of the bus2ip slave; 32-bit registers on word addresses, unmapped ones flag an error
package reg_map_pkg;

   localparam int addr_w = 11; // bus2ip_addr width
   localparam int reg_w  = 32; // Register and bus data width
   localparam int cnt_w  = 32; // Frame counters, saturating

   localparam logic [reg_w-1:0] core_id = 32'h4c50_0100; // "LP" v1.0

   // Control register bits
   localparam int ctrl_swap_en_bit = 0; // Resets to 1
   localparam int ctrl_clear_bit   = 1; // Self-clearing

   // Mapped registers
   typedef enum logic [addr_w-1:0] {
      reg_id        = 11'h000, // RO
      reg_ctrl      = 11'h004, // RW
      reg_rx_good   = 11'h008, // RO
      reg_rx_bad    = 11'h00C, // RO
      reg_tx_frames = 11'h010  // RO
   } reg_addr_e;

   // Access kind, from bus2ip_rnw
   typedef enum logic {
      bus_write = 1'b0,
      bus_read  = 1'b1
   } bus_op_e;

endpackage

//--- logic/xgmac_address_swap.sv
// Needs frames of two beats or more with 12 valid header bytes; one-beat frames pass untouched
`timescale 1ns/1ps

module xgmac_address_swap (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            swap_en,
   input  logic [loopback_pkg::data_w-1:0] rx_axis_tdata,
   input  logic [loopback_pkg::keep_w-1:0] rx_axis_tkeep,
   input  logic                            rx_axis_tlast,
   input  logic                            rx_axis_tvalid,
   output logic                            rx_axis_tready,
   output logic [loopback_pkg::data_w-1:0] tx_axis_tdata,
   output logic [loopback_pkg::keep_w-1:0] tx_axis_tkeep,
   output logic                            tx_axis_tlast,
   output logic                            tx_axis_tvalid,
   input  logic                            tx_axis_tready
);
   import loopback_pkg::*;

   swap_state_e         state;
   swap_state_e         state_nxt;
   logic [data_w-1:0]   hold_data;   // The one held beat
   logic [keep_w-1:0]   hold_keep;
   logic                hold_last;
   logic                frame_swap;  // swap_en taken at frame start
   logic                out_free;    // Output reg can take a beat
   logic                rx_fire;     // rx handshake
   logic                hold_leaves; // Held beat moves to output
   logic                sof;         // Next accepted beat starts a frame
   logic                first_pair;  // Beat 0 held and swapping
   logic [2*data_w-1:0] pair;        // Beat 1 over beat 0
   logic [2*data_w-1:0] swapped;

   // Output register empty or draining this cycle
   assign out_free = !tx_axis_tvalid || tx_axis_tready;

   // Empty hold always accepts; full hold only if it can leave now
   assign rx_axis_tready = (state == swap_idle) || out_free;
   assign rx_fire        = rx_axis_tvalid && rx_axis_tready;

   // A last beat leaves alone, any other one waits for its successor
   assign hold_leaves = (state != swap_idle) && out_free && (hold_last || rx_axis_tvalid);

   // hold_last is stale in idle but sof is true there anyway
   assign sof        = (state == swap_idle) || hold_last;
   assign first_pair = (state == swap_first_held) && frame_swap;

   // Header bytes 0-15 across the two beats
   assign pair = {rx_axis_tdata, hold_data};

   always_comb begin
      swapped = pair;
      for (int i = 0; i < mac_bytes; i++) begin
         swapped[(dst_ofs + i)*byte_w +: byte_w] = pair[(src_ofs + i)*byte_w +: byte_w];
         swapped[(src_ofs + i)*byte_w +: byte_w] = pair[(dst_ofs + i)*byte_w +: byte_w];
      end
   end

   always_comb begin
      state_nxt = state;
      if (rx_fire) begin
         if (!sof || rx_axis_tlast) begin
            state_nxt = swap_streaming; // Later beat, or single-beat frame
         end else begin
            state_nxt = swap_first_held;
         end
      end else if (hold_leaves) begin
         state_nxt = swap_idle;         // Last beat gone, nothing behind it
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= swap_idle;
         frame_swap <= 1'b1;
      end else begin
         state <= state_nxt;
         if (rx_fire && sof) begin
            frame_swap <= swap_en; // Fixed for the whole frame
         end
      end
   end

   // Hold register; beat 1 already gets its rewritten bytes 0-3
   always_ff @(posedge clk) begin
      if (rx_fire) begin
         hold_data <= first_pair ? swapped[2*data_w-1:data_w] : rx_axis_tdata;
         hold_keep <= rx_axis_tkeep;
         hold_last <= rx_axis_tlast;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_axis_tvalid <= 1'b0;
      end else if (hold_leaves) begin
         tx_axis_tvalid <= 1'b1;
      end else if (tx_axis_tready) begin
         tx_axis_tvalid <= 1'b0; // Drained, nothing new
      end
   end

   // Output payload
   always_ff @(posedge clk) begin
      if (hold_leaves) begin
         tx_axis_tdata <= first_pair ? swapped[data_w-1:0] : hold_data;
         tx_axis_tkeep <= hold_keep;
         tx_axis_tlast <= hold_last;
      end
   end

   // Stalled output beat stays put
   a_tx_stable: assert property (@(posedge clk) disable iff (!rst_n)
      tx_axis_tvalid && !tx_axis_tready |=>
         tx_axis_tvalid && $stable(tx_axis_tdata) && $stable(tx_axis_tkeep)
         && $stable(tx_axis_tlast));

   // Full hold behind a stalled output takes nothing
   a_no_accept_full: assert property (@(posedge clk) disable iff (!rst_n)
      (state inside {swap_first_held, swap_streaming}) && tx_axis_tvalid && !tx_axis_tready
         |-> !rx_fire);

endmodule

//--- vlog.f
+incdir+dv
logic/loopback_pkg.sv
logic/reg_map_pkg.sv
logic/xgmac_address_swap.sv
logic/frame_stats.sv
logic/loopback_regs.sv
logic/mac_loopback.sv
dv/tb_mac_loopback.sv
